// ==== Makefile ====
TOP := ps2_mouse_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

// ==== design/mouse_cfg_regs.sv ====
`default_nettype none

`include "ps2_mouse_consts.svh"

module mouse_cfg_regs
        import ps2_mouse_pkg::*;
(
        input  logic      clk,
        input  logic      rstn,
        input  logic      cfg_wr,
        input  cfg_addr_t cfg_addr,
        input  cfg_data_t cfg_wdata,
        input  logic      frame_err,
        output cfg_data_t cfg_rdata,
        output logic      track_en,
        output logic      home,
        output coord_t    x_max,
        output coord_t    y_max
);

        err_cnt_t err_cnt;

        // ------------------------------
        // Writes
        // ------------------------------
        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        track_en <= 1'b1;
                        home     <= 1'b0;
                        x_max    <= `PS2_X_MAX_RST;
                        y_max    <= `PS2_Y_MAX_RST;
                        err_cnt  <= '0;
                end else begin
                        home <= cfg_wr && cfg_addr == `PS2_REG_CTRL &&
                                cfg_wdata[`PS2_CTRL_HOME_BIT];
                        if (cfg_wr) begin
                                case (cfg_addr)
                                `PS2_REG_CTRL: track_en <= cfg_wdata[`PS2_CTRL_EN_BIT];
                                `PS2_REG_XMAX: x_max    <= cfg_wdata[9:0];
                                `PS2_REG_YMAX: y_max    <= cfg_wdata[9:0];
                                default:       ;        // Error count is read only
                                endcase
                        end
                        if (frame_err && err_cnt != 8'hff)
                                err_cnt <= err_cnt + 8'd1;  // Saturates
                end
        end

        always_comb begin
                case (cfg_addr)
                `PS2_REG_CTRL: cfg_rdata = cfg_data_t'(track_en);
                `PS2_REG_XMAX: cfg_rdata = cfg_data_t'(x_max);
                `PS2_REG_YMAX: cfg_rdata = cfg_data_t'(y_max);
                default:       cfg_rdata = cfg_data_t'(err_cnt);
                endcase
        end

endmodule

`default_nettype wire

// ==== design/mouse_cursor_track.sv ====
`default_nettype none

module mouse_cursor_track
        import ps2_mouse_pkg::*;
(
        input  logic     clk,
        input  logic     rstn,
        input  logic     pkt_valid,
        input  buttons_t pkt_buttons,
        input  delta_t   pkt_dx,
        input  delta_t   pkt_dy,
        input  logic     pkt_x_ovf,
        input  logic     pkt_y_ovf,
        input  logic     track_en,
        input  logic     home,
        input  coord_t   x_max,
        input  coord_t   y_max,
        output coord_t   cursor_x,
        output coord_t   cursor_y,
        output buttons_t buttons,
        output logic     cursor_upd
);

        // 12 bits signed holds -256 up to 1023 + 255
        function automatic coord_t clamp_axis(coord_t pos, delta_t d, coord_t max);
                logic signed [11:0] sum;
                logic signed [11:0] lim;
                sum = signed'({2'b00, pos}) + signed'({{3{d[8]}}, d});
                lim = signed'({2'b00, max});
                if (sum < 12'sd0)
                        return '0;
                else if (sum > lim)
                        return max;
                else
                        return sum[9:0];
        endfunction

        // ------------------------------
        // Position update
        // ------------------------------
        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        cursor_x   <= '0;
                        cursor_y   <= '0;
                        buttons    <= '0;
                        cursor_upd <= 1'b0;
                end else begin
                        cursor_upd <= pkt_valid && track_en;
                        if (home) begin
                                cursor_x <= x_max >> 1;
                                cursor_y <= y_max >> 1;
                        end else if (pkt_valid && track_en) begin
                                if (!pkt_x_ovf)
                                        cursor_x <= clamp_axis(cursor_x, pkt_dx, x_max);
                                if (!pkt_y_ovf)
                                        cursor_y <= clamp_axis(cursor_y, pkt_dy, y_max);
                                buttons <= pkt_buttons;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== design/mouse_packet_asm.sv ====
`default_nettype none

module mouse_packet_asm
        import ps2_mouse_pkg::*;
(
        input  logic      clk,
        input  logic      rstn,
        input  ps2_byte_t byte_data,
        input  logic      byte_valid,
        input  logic      frame_err,
        output logic      pkt_valid,
        output buttons_t  pkt_buttons,
        output delta_t    pkt_dx,
        output delta_t    pkt_dy,
        output logic      pkt_x_ovf,
        output logic      pkt_y_ovf
);

        pkt_state_t state;
        ps2_byte_t  b0_byte;
        ps2_byte_t  b1_byte;

        // ------------------------------
        // Byte counter
        // ------------------------------
        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        state     <= pkt_b0;
                        pkt_valid <= 1'b0;
                end else begin
                        pkt_valid <= 1'b0;
                        if (frame_err) begin
                                state <= pkt_b0;        // Drop partial packet
                        end else if (byte_valid) begin
                                case (state)
                                pkt_b0: begin
                                        if (byte_data[3])
                                                state <= pkt_b1;
                                end
                                pkt_b1: state <= pkt_b2;
                                pkt_b2: begin
                                        state     <= pkt_b0;
                                        pkt_valid <= 1'b1;
                                end
                                default: state <= pkt_b0;
                                endcase
                        end
                end
        end

        // Packet fields hold until the next packet
        always_ff @(posedge clk) begin
                if (byte_valid && !frame_err) begin
                        if (state == pkt_b0)
                                b0_byte <= byte_data;
                        if (state == pkt_b1)
                                b1_byte <= byte_data;
                        if (state == pkt_b2) begin
                                pkt_buttons <= b0_byte[2:0];
                                pkt_dx      <= {b0_byte[4], b1_byte};
                                pkt_dy      <= {b0_byte[5], byte_data};
                                pkt_x_ovf   <= b0_byte[6];
                                pkt_y_ovf   <= b0_byte[7];
                        end
                end
        end

endmodule

`default_nettype wire

// ==== design/ps2_frame_rx.sv ====
`default_nettype none

`include "ps2_mouse_consts.svh"

module ps2_frame_rx
        import ps2_mouse_pkg::*;
(
        input  logic      clk,
        input  logic      rstn,
        input  logic      ps2_clk,
        input  logic      ps2_data,
        output ps2_byte_t byte_data,
        output logic      byte_valid,
        output logic      frame_err
);

        logic [2:0]  clk_sync;     // Two sync stages, then edge register
        logic [1:0]  data_sync;
        logic        clk_fall;
        logic        rx_bit;
        rx_state_t   state;
        logic [2:0]  bit_cnt;
        logic        parity;       // Ends at 1 for good odd parity
        ps2_byte_t   shift_reg;
        logic [10:0] timeout_cnt;

        // ------------------------------
        // Line synchronizers
        // ------------------------------
        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        clk_sync  <= 3'b111;          // Idle lines are high
                        data_sync <= 2'b11;
                end else begin
                        clk_sync  <= {clk_sync[1:0], ps2_clk};
                        data_sync <= {data_sync[0], ps2_data};
                end
        end

        assign clk_fall = clk_sync[2] & ~clk_sync[1];
        assign rx_bit   = data_sync[1];

        // ------------------------------
        // Frame FSM
        // ------------------------------
        always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                        state       <= rx_idle;
                        bit_cnt     <= 3'd0;
                        parity      <= 1'b0;
                        timeout_cnt <= 11'(`PS2_IDLE_TIMEOUT);
                        byte_valid  <= 1'b0;
                        frame_err   <= 1'b0;
                end else begin
                        byte_valid <= 1'b0;
                        frame_err  <= 1'b0;
                        if (clk_fall)
                                timeout_cnt <= 11'(`PS2_IDLE_TIMEOUT);
                        else if (state != rx_idle && timeout_cnt != 11'd0)
                                timeout_cnt <= timeout_cnt - 11'd1;

                        case (state)
                        rx_idle: begin
                                if (clk_fall && !rx_bit) begin  // Start bit
                                        state   <= rx_data;
                                        bit_cnt <= 3'd0;
                                        parity  <= 1'b0;
                                end
                        end
                        rx_data: begin
                                if (clk_fall) begin
                                        parity  <= parity ^ rx_bit;
                                        bit_cnt <= bit_cnt + 3'd1;
                                        if (bit_cnt == 3'd7)
                                                state <= rx_parity;
                                end
                        end
                        rx_parity: begin
                                if (clk_fall) begin
                                        parity <= parity ^ rx_bit;
                                        state  <= rx_stop;
                                end
                        end
                        rx_stop: begin
                                if (clk_fall) begin
                                        state <= rx_idle;
                                        if (rx_bit && parity)
                                                byte_valid <= 1'b1;
                                        else
                                                frame_err <= 1'b1;
                                end
                        end
                        default: state <= rx_idle;
                        endcase

                        // Stalled frame
                        if (state != rx_idle && !clk_fall && timeout_cnt == 11'd0) begin
                                state     <= rx_idle;
                                frame_err <= 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (state == rx_data && clk_fall)
                        shift_reg <= {rx_bit, shift_reg[7:1]};  // LSB first
                if (state == rx_stop && clk_fall)
                        byte_data <= shift_reg;
        end

endmodule

`default_nettype wire

// ==== design/ps2_mouse_pkg.sv ====
`default_nettype none

package ps2_mouse_pkg;

        // ------------------------------
        // Vector types
        // ------------------------------
        typedef logic [7:0]         ps2_byte_t;
        typedef logic signed [8:0]  delta_t;    // Sign bit from byte 0
        typedef logic [9:0]         coord_t;
        typedef logic [2:0]         buttons_t;  // Left, right, middle
        typedef logic [1:0]         cfg_addr_t;
        typedef logic [15:0]        cfg_data_t;
        typedef logic [7:0]         err_cnt_t;

        // ------------------------------
        // State machines
        // ------------------------------
        typedef enum logic [1:0] {
                rx_idle,
                rx_data,
                rx_parity,
                rx_stop
        } rx_state_t;

        typedef enum logic [1:0] {
                pkt_b0,
                pkt_b1,
                pkt_b2
        } pkt_state_t;

endpackage

`default_nettype wire

// ==== design/ps2_mouse_top.sv ====
`default_nettype none

module ps2_mouse_top
        import ps2_mouse_pkg::*;
(
        input  logic      clk,
        input  logic      rstn,
        input  logic      ps2_clk,
        input  logic      ps2_data,
        input  logic      cfg_wr,
        input  cfg_addr_t cfg_addr,
        input  cfg_data_t cfg_wdata,
        output cfg_data_t cfg_rdata,
        output coord_t    cursor_x,
        output coord_t    cursor_y,
        output buttons_t  buttons,
        output logic      cursor_upd
);

        ps2_byte_t byte_data;
        logic      byte_valid;
        logic      frame_err;
        logic      pkt_valid;
        buttons_t  pkt_buttons;
        delta_t    pkt_dx;
        delta_t    pkt_dy;
        logic      pkt_x_ovf;
        logic      pkt_y_ovf;
        logic      track_en;
        logic      home;
        coord_t    x_max;
        coord_t    y_max;

        // ------------------------------
        // Receive path
        // ------------------------------
        ps2_frame_rx frame_rx_i (
                .clk        (clk),
                .rstn       (rstn),
                .ps2_clk    (ps2_clk),
                .ps2_data   (ps2_data),
                .byte_data  (byte_data),
                .byte_valid (byte_valid),
                .frame_err  (frame_err)
        );

        mouse_packet_asm packet_asm_i (
                .clk         (clk),
                .rstn        (rstn),
                .byte_data   (byte_data),
                .byte_valid  (byte_valid),
                .frame_err   (frame_err),
                .pkt_valid   (pkt_valid),
                .pkt_buttons (pkt_buttons),
                .pkt_dx      (pkt_dx),
                .pkt_dy      (pkt_dy),
                .pkt_x_ovf   (pkt_x_ovf),
                .pkt_y_ovf   (pkt_y_ovf)
        );

        // ------------------------------
        // Config and tracking
        // ------------------------------
        mouse_cfg_regs cfg_regs_i (
                .clk       (clk),
                .rstn      (rstn),
                .cfg_wr    (cfg_wr),
                .cfg_addr  (cfg_addr),
                .cfg_wdata (cfg_wdata),
                .frame_err (frame_err),
                .cfg_rdata (cfg_rdata),
                .track_en  (track_en),
                .home      (home),
                .x_max     (x_max),
                .y_max     (y_max)
        );

        mouse_cursor_track cursor_track_i (
                .clk         (clk),
                .rstn        (rstn),
                .pkt_valid   (pkt_valid),
                .pkt_buttons (pkt_buttons),
                .pkt_dx      (pkt_dx),
                .pkt_dy      (pkt_dy),
                .pkt_x_ovf   (pkt_x_ovf),
                .pkt_y_ovf   (pkt_y_ovf),
                .track_en    (track_en),
                .home        (home),
                .x_max       (x_max),
                .y_max       (y_max),
                .cursor_x    (cursor_x),
                .cursor_y    (cursor_y),
                .buttons     (buttons),
                .cursor_upd  (cursor_upd)
        );

endmodule

`default_nettype wire

// ==== include/ps2_mouse_consts.svh ====
`ifndef PS2_MOUSE_CONSTS_SVH
`define PS2_MOUSE_CONSTS_SVH

// Screen bounds after reset
`define PS2_X_MAX_RST     10'd639
`define PS2_Y_MAX_RST     10'd479

`define PS2_IDLE_TIMEOUT  2000     // clk cycles without a ps2_clk fall

// Register map
`define PS2_REG_CTRL      2'd0
`define PS2_REG_XMAX      2'd1
`define PS2_REG_YMAX      2'd2
`define PS2_REG_ERRCNT    2'd3

`define PS2_CTRL_EN_BIT   0
`define PS2_CTRL_HOME_BIT 1        // Write only

`endif

// ==== sim.f ====
+incdir+include
design/ps2_mouse_pkg.sv
design/ps2_frame_rx.sv
design/mouse_packet_asm.sv
design/mouse_cursor_track.sv
design/mouse_cfg_regs.sv
design/ps2_mouse_top.sv
verif/tb_clk_gen.sv
verif/ps2_mouse_properties.sv
verif/ps2_mouse_tb.sv

// ==== verif/ps2_mouse_properties.sv ====
`default_nettype none

`include "ps2_mouse_consts.svh"

module ps2_mouse_properties
        import ps2_mouse_pkg::*;
(
        input logic      clk,
        input logic      rstn,
        input logic      cfg_wr,
        input cfg_addr_t cfg_addr,
        input coord_t    cursor_x,
        input coord_t    cursor_y,
        input coord_t    x_max,
        input coord_t    y_max,
        input logic      pkt_valid,
        input logic      track_en,
        input logic      cursor_upd,
        input logic      byte_valid,
        input logic      frame_err
);

        // ------------------------------
        // Cursor bounds
        // ------------------------------
        x_bound: assert property (@(posedge clk) disable iff (!rstn)
                !$past(cfg_wr && cfg_addr == `PS2_REG_XMAX) |-> cursor_x <= x_max)
                else $error("cursor_x above x_max");

        y_bound: assert property (@(posedge clk) disable iff (!rstn)
                !$past(cfg_wr && cfg_addr == `PS2_REG_YMAX) |-> cursor_y <= y_max)
                else $error("cursor_y above y_max");

        // ------------------------------
        // Strobes
        // ------------------------------
        upd_follows_pkt: assert property (@(posedge clk) disable iff (!rstn)
                pkt_valid && track_en |=> cursor_upd)
                else $error("cursor_upd missing after pkt_valid");

        byte_xor_err: assert property (@(posedge clk) disable iff (!rstn)
                !(byte_valid && frame_err))
                else $error("byte_valid and frame_err together");

endmodule

bind ps2_mouse_top ps2_mouse_properties props_i (
        .clk        (clk),
        .rstn       (rstn),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y),
        .x_max      (x_max),
        .y_max      (y_max),
        .pkt_valid  (pkt_valid),
        .track_en   (track_en),
        .cursor_upd (cursor_upd),
        .byte_valid (byte_valid),
        .frame_err  (frame_err)
);

`default_nettype wire

// ==== verif/ps2_mouse_tb.sv ====
`default_nettype none

`include "ps2_mouse_consts.svh"

module ps2_mouse_tb
        import ps2_mouse_pkg::*;
();

        logic      clk;
        logic      rstn;
        logic      ps2_clk;
        logic      ps2_data;
        logic      cfg_wr;
        cfg_addr_t cfg_addr;
        cfg_data_t cfg_wdata;
        cfg_data_t cfg_rdata;
        coord_t    cursor_x;
        coord_t    cursor_y;
        buttons_t  buttons;
        logic      cursor_upd;

        // Reference model
        coord_t    model_x;
        coord_t    model_y;
        coord_t    model_xmax;
        coord_t    model_ymax;
        buttons_t  model_btn;
        err_cnt_t  model_err;

        int        upd_count = 0;       // cursor_upd pulses seen
        int        upd_taken = 0;       // Pulses already consumed by a check

        tb_clk_gen clk_gen_i (.clk(clk));

        ps2_mouse_top dut_i (
                .clk        (clk),
                .rstn       (rstn),
                .ps2_clk    (ps2_clk),
                .ps2_data   (ps2_data),
                .cfg_wr     (cfg_wr),
                .cfg_addr   (cfg_addr),
                .cfg_wdata  (cfg_wdata),
                .cfg_rdata  (cfg_rdata),
                .cursor_x   (cursor_x),
                .cursor_y   (cursor_y),
                .buttons    (buttons),
                .cursor_upd (cursor_upd)
        );

        always @(posedge clk) begin
                if (rstn && cursor_upd)
                        upd_count <= upd_count + 1;
        end

        // ------------------------------
        // Checks
        // ------------------------------
        task automatic fail_stop(input string why);
                $display("%s", why);
                $display("TEST FAIL");
                $fatal(1, "stopped at first error");
        endtask

        task automatic check_coord(input string name, input coord_t got, input coord_t exp);
                if (got !== exp)
                        fail_stop($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                            $time, name, got, exp));
        endtask

        task automatic check_buttons(input string name, input buttons_t got,
                                     input buttons_t exp);
                if (got !== exp)
                        fail_stop($sformatf("mismatch at %0t: %s got %b expected %b",
                                            $time, name, got, exp));
        endtask

        task automatic check_cfg(input string name, input cfg_data_t got, input cfg_data_t exp);
                if (got !== exp)
                        fail_stop($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                            $time, name, got, exp));
        endtask

        task automatic check_errcnt(input string name, input err_cnt_t got, input err_cnt_t exp);
                if (got !== exp)
                        fail_stop($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                            $time, name, got, exp));
        endtask

        function automatic coord_t clamp_ref(input int pos, input int d, input int max);
                int s;
                s = pos + d;
                if (s < 0)
                        s = 0;
                if (s > max)
                        s = max;
                return coord_t'(s);
        endfunction

        // ------------------------------
        // Bus and device drivers
        // ------------------------------
        task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
                @(negedge clk);
                cfg_wr    = 1'b1;
                cfg_addr  = addr;
                cfg_wdata = data;
                @(negedge clk);
                cfg_wr = 1'b0;
        endtask

        task automatic read_reg(input cfg_addr_t addr, output cfg_data_t data);
                @(negedge clk);
                cfg_addr = addr;
                @(negedge clk);
                data = cfg_rdata;
        endtask

        // Start, 8 data bits LSB first, odd parity, stop
        task automatic send_byte(input ps2_byte_t b, input bit bad_parity, input bit bad_stop);
                logic [10:0] frame;
                int          i;
                frame = {~bad_stop, (~^b) ^ bad_parity, b, 1'b0};
                for (i = 0; i < 11; i++) begin
                        @(negedge clk);
                        ps2_data = frame[i];
                        repeat (8) @(negedge clk);
                        ps2_clk = 1'b0;
                        repeat (8) @(negedge clk);
                        ps2_clk = 1'b1;
                end
                @(negedge clk);
                ps2_data = 1'b1;
                repeat (16) @(negedge clk);     // Inter-byte gap
        endtask

        task automatic send_packet(input ps2_byte_t b0, input ps2_byte_t b1, input ps2_byte_t b2);
                send_byte(b0, 1'b0, 1'b0);
                send_byte(b1, 1'b0, 1'b0);
                send_byte(b2, 1'b0, 1'b0);
        endtask

        function automatic ps2_byte_t status_byte(input int dx, input int dy, input buttons_t btn,
                                                  input bit xo, input bit yo);
                return {yo, xo, dy < 0, dx < 0, 1'b1, btn};
        endfunction

        task automatic wait_cursor_upd();
                int n;
                n = 0;
                while (upd_count == upd_taken && n < 400) begin
                        @(negedge clk);
                        n++;
                end
                if (upd_count == upd_taken)
                        fail_stop("timeout: no cursor update arrived");
                if (upd_count != upd_taken + 1)
                        fail_stop("more than one cursor update for a single packet");
                upd_taken++;
        endtask

        task automatic wait_no_upd();
                int n;
                for (n = 0; n < 400; n++)
                        @(negedge clk);
                if (upd_count != upd_taken)
                        fail_stop("cursor update arrived while tracking was disabled");
        endtask

        task automatic move_and_check(input int dx, input int dy, input buttons_t btn,
                                      input bit xo, input bit yo);
                send_packet(status_byte(dx, dy, btn, xo, yo), dx[7:0], dy[7:0]);
                wait_cursor_upd();
                if (!xo)
                        model_x = clamp_ref(model_x, dx, model_xmax);
                if (!yo)
                        model_y = clamp_ref(model_y, dy, model_ymax);
                model_btn = btn;
                check_coord("cursor_x", cursor_x, model_x);
                check_coord("cursor_y", cursor_y, model_y);
                check_buttons("buttons", buttons, model_btn);
        endtask

        // ------------------------------
        // Directed tests
        // ------------------------------
        task automatic reset_defaults();
                cfg_data_t d;
                read_reg(`PS2_REG_CTRL, d);
                check_cfg("ctrl", d, 16'd1);
                read_reg(`PS2_REG_XMAX, d);
                check_cfg("x_max", d, 16'd639);
                read_reg(`PS2_REG_YMAX, d);
                check_cfg("y_max", d, 16'd479);
                read_reg(`PS2_REG_ERRCNT, d);
                check_errcnt("err_cnt", d[7:0], 8'd0);
                check_coord("cursor_x", cursor_x, 10'd0);
                check_coord("cursor_y", cursor_y, 10'd0);
                check_buttons("buttons", buttons, 3'd0);
        endtask

        task automatic register_access();
                cfg_data_t d;
                write_reg(`PS2_REG_XMAX, 16'd500);
                write_reg(`PS2_REG_YMAX, 16'd300);
                model_xmax = 10'd500;
                model_ymax = 10'd300;
                read_reg(`PS2_REG_XMAX, d);
                check_cfg("x_max", d, 16'd500);
                read_reg(`PS2_REG_YMAX, d);
                check_cfg("y_max", d, 16'd300);
                write_reg(`PS2_REG_ERRCNT, 16'h0055);   // Read only
                read_reg(`PS2_REG_ERRCNT, d);
                check_cfg("err_cnt", d, 16'd0);
        endtask

        task automatic random_movement();
                int i;
                int dx;
                int dy;
                move_and_check(-256, -256, 3'b000, 1'b0, 1'b0);        // Floor at 0
                for (i = 0; i < 20; i++) begin
                        dx = int'($urandom_range(511, 0)) - 256;
                        dy = int'($urandom_range(511, 0)) - 256;
                        move_and_check(dx, dy, buttons_t'($urandom_range(7, 0)), 1'b0, 1'b0);
                end
                for (i = 0; i < 3; i++)
                        move_and_check(255, 255, 3'b101, 1'b0, 1'b0);  // Up to the bounds
        endtask

        task automatic overflow_and_disable();
                cfg_data_t d;
                move_and_check(-100, -100, 3'b000, 1'b0, 1'b0);
                move_and_check(40, -25, 3'b001, 1'b1, 1'b0);
                move_and_check(-30, 20, 3'b010, 1'b0, 1'b1);
                write_reg(`PS2_REG_CTRL, 16'd0);
                read_reg(`PS2_REG_CTRL, d);
                check_cfg("ctrl", d, 16'd0);
                send_packet(status_byte(60, 60, 3'b111, 1'b0, 1'b0), 8'd60, 8'd60);
                wait_no_upd();
                check_coord("cursor_x", cursor_x, model_x);
                check_coord("cursor_y", cursor_y, model_y);
                check_buttons("buttons", buttons, model_btn);
                write_reg(`PS2_REG_CTRL, 16'd1);
        endtask

        task automatic error_recovery();
                cfg_data_t d;
                // Bad parity right after a first byte
                send_byte(status_byte(5, 5, 3'b000, 1'b0, 1'b0), 1'b0, 1'b0);
                send_byte(8'h12, 1'b1, 1'b0);
                model_err++;
                read_reg(`PS2_REG_ERRCNT, d);
                check_errcnt("err_cnt", d[7:0], model_err);
                move_and_check(12, -7, 3'b100, 1'b0, 1'b0);
                // Bad stop on the third byte
                send_byte(status_byte(5, 5, 3'b000, 1'b0, 1'b0), 1'b0, 1'b0);
                send_byte(8'h20, 1'b0, 1'b0);
                send_byte(8'h30, 1'b0, 1'b1);
                model_err++;
                read_reg(`PS2_REG_ERRCNT, d);
                check_errcnt("err_cnt", d[7:0], model_err);
                move_and_check(-9, 14, 3'b011, 1'b0, 1'b0);
                send_byte(8'h05, 1'b0, 1'b0);   // Stray byte, bit 3 clear
                read_reg(`PS2_REG_ERRCNT, d);
                check_errcnt("err_cnt", d[7:0], model_err);
                move_and_check(21, 3, 3'b001, 1'b0, 1'b0);
        endtask

        task automatic recenter();
                cfg_data_t d;
                write_reg(`PS2_REG_CTRL, 16'd3);
                read_reg(`PS2_REG_CTRL, d);
                check_cfg("ctrl", d, 16'd1);    // Home bit is not stored
                model_x = model_xmax >> 1;
                model_y = model_ymax >> 1;
                move_and_check(0, 0, 3'b010, 1'b0, 1'b0);
        endtask

        initial begin
                void'($urandom(32'h0437946c));
                rstn       = 1'b0;
                ps2_clk    = 1'b1;
                ps2_data   = 1'b1;
                cfg_wr     = 1'b0;
                cfg_addr   = '0;
                cfg_wdata  = '0;
                model_x    = '0;
                model_y    = '0;
                model_btn  = '0;
                model_err  = '0;
                model_xmax = `PS2_X_MAX_RST;
                model_ymax = `PS2_Y_MAX_RST;
                repeat (10) @(negedge clk);
                rstn = 1'b1;

                reset_defaults();
                register_access();
                random_movement();
                overflow_and_disable();
                error_recovery();
                recenter();

                $display("TEST PASS");
                $finish;
        end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
        output logic clk
);

        initial clk = 1'b0;

        always #5 clk = ~clk;           // Period 10

endmodule

`default_nettype wire
